//--- hw/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------

    localparam int XLEN = 32;

    // ROB holds 16 in-flight results
    localparam int ROB_TAG_W = 4;

    typedef logic [XLEN-1:0] word_t;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // ------------------------------------------------------------------
    // writeback bundle
    // ------------------------------------------------------------------

    // one result broadcast, used for the CDB and the local wakeup
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } wb_bus_t;

endpackage

`default_nettype wire

//--- hw/iq_pkg.sv
`default_nettype none

package iq_pkg;

    import core_types_pkg::*;

    localparam int IQ_SIZE = 4;
    localparam int IQ_IDX_W = 2;
    // free count has to reach IQ_SIZE itself
    localparam int IQ_CNT_W = $clog2(IQ_SIZE + 1);
    // saturating age, tops out at 15
    localparam int AGE_W = 4;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // source operand, value is only meaningful once rdy is set
    typedef struct packed {
        logic     rdy;
        rob_tag_t tag;
        word_t    val;
    } src_t;

    typedef struct packed {
        alu_op_e        op;
        rob_tag_t       dst;
        src_t [1:0]     src;
    } uop_t;

endpackage

`default_nettype wire

//--- hw/iq_dispatch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface iq_dispatch_if
    import iq_pkg::*;
();

    logic valid;
    logic ready;
    uop_t uop;

    // dispatch side
    modport sender (
        output valid,
        output uop,
        input  ready
    );

    // queue side
    modport receiver (
        input  valid,
        input  uop,
        output ready
    );

endinterface

`default_nettype wire

//--- hw/iq_entry.sv
`timescale 1ns/1ps
`default_nettype none

module iq_entry
    import core_types_pkg::*;
    import iq_pkg::*;
(
    input  wire     clk,
    input  wire     arst_n_i,
    input  wire     flush_i,

    input  logic    alloc_i,
    input  uop_t    uop_i,

    input  wb_bus_t cdb_i,
    input  wb_bus_t self_i,

    input  logic    issue_i,

    output logic    valid_o,
    output logic    ready_o,
    output uop_t    uop_o
);

    logic valid_q;
    uop_t uop_q;
    uop_t uop_d;

    // capture a broadcast value for a source still waiting on its tag
    function automatic src_t wake_src(src_t src, wb_bus_t cdb, wb_bus_t loc);
        src_t res;
        res = src;
        if (!src.rdy) begin
            if (cdb.valid && (cdb.tag == src.tag)) begin
                res.rdy = 1'b1;
                res.val = cdb.data;
            end else if (loc.valid && (loc.tag == src.tag)) begin
                res.rdy = 1'b1;
                res.val = loc.data;
            end
        end
        return res;
    endfunction

    // ------------------------------------------------------------------
    // next payload, new uop or wakeup of the held one
    // ------------------------------------------------------------------

    always_comb begin
        uop_d = alloc_i ? uop_i : uop_q;
        for (int s = 0; s < 2; s++) begin
            uop_d.src[s] = wake_src(uop_d.src[s], cdb_i, self_i);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (alloc_i) begin
            valid_q <= 1'b1;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end
    end

    // payload only, qualified by valid_q
    always_ff @(posedge clk) begin
        uop_q <= uop_d;
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && uop_q.src[0].rdy && uop_q.src[1].rdy;
    assign uop_o   = uop_q;

endmodule

`default_nettype wire

//--- hw/age_select.sv
`timescale 1ns/1ps
`default_nettype none

module age_select
    import iq_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  wire                 flush_i,

    input  logic [IQ_SIZE-1:0]  valid_i,
    input  logic [IQ_SIZE-1:0]  ready_i,
    input  logic [IQ_SIZE-1:0]  alloc_i,
    input  logic                advance_i,

    output logic [IQ_SIZE-1:0]  grant_o
);

    logic [AGE_W-1:0] age_q [IQ_SIZE];

    // ------------------------------------------------------------------
    // age counters
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (flush_i || alloc_i[i]) begin
                    age_q[i] <= '0;
                end else if (valid_i[i] && (age_q[i] != '1)) begin
                    age_q[i] <= age_q[i] + AGE_W'(1);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // oldest ready entry, strict compare keeps ties on the lower index
    // ------------------------------------------------------------------

    always_comb begin
        logic                found;
        logic [AGE_W-1:0]    best_age;
        logic [IQ_IDX_W-1:0] best_idx;
        found    = 1'b0;
        best_age = '0;
        best_idx = '0;
        grant_o  = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (ready_i[i] && (!found || (age_q[i] > best_age))) begin
                found    = 1'b1;
                best_age = age_q[i];
                best_idx = IQ_IDX_W'(i);
            end
        end
        if (found && advance_i) begin
            grant_o[best_idx] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec
    import core_types_pkg::*;
    import iq_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n_i,
    input  wire         flush_i,

    input  logic        load_i,
    input  alu_op_e     op_i,
    input  word_t       a_i,
    input  word_t       b_i,
    input  rob_tag_t    tag_i,

    output logic        res_valid_o,
    output rob_tag_t    res_tag_o,
    output word_t       res_data_o,

    input  logic        hold_i
);

    word_t alu_res;
    logic  res_valid_q;

    // ------------------------------------------------------------------
    // combinational ALU
    // ------------------------------------------------------------------

    always_comb begin
        case (op_i)
            ALU_ADD: alu_res = a_i + b_i;
            ALU_SUB: alu_res = a_i - b_i;
            ALU_AND: alu_res = a_i & b_i;
            ALU_OR:  alu_res = a_i | b_i;
            ALU_XOR: alu_res = a_i ^ b_i;
            // shift amount from low 5 bits only
            ALU_SLL: alu_res = a_i << b_i[4:0];
            ALU_SRL: alu_res = a_i >> b_i[4:0];
            ALU_SLT: alu_res = ($signed(a_i) < $signed(b_i)) ? word_t'(1) : word_t'(0);
            default: alu_res = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // result register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else if (load_i) begin
            res_valid_q <= 1'b1;
        end else if (!hold_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            res_tag_o  <= tag_i;
            res_data_o <= alu_res;
        end
    end

    assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

//--- hw/alu_iq.sv
`timescale 1ns/1ps
`default_nettype none

module alu_iq
    import core_types_pkg::*;
    import iq_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     flush_i,

    iq_dispatch_if.receiver         disp,

    input  wb_bus_t                 cdb_i,

    input  logic                    res_ready_i,
    output logic                    res_valid_o,
    output rob_tag_t                res_tag_o,
    output word_t                   res_data_o
);

    logic [IQ_SIZE-1:0] entry_valid;
    logic [IQ_SIZE-1:0] entry_ready;
    logic [IQ_SIZE-1:0] alloc;
    logic [IQ_SIZE-1:0] grant;
    uop_t               entry_uop [IQ_SIZE];

    logic                disp_fire;
    logic                issue_fire;
    logic                advance;
    logic [IQ_CNT_W-1:0] free_q;
    logic [IQ_CNT_W-1:0] free_d;
    logic                disp_ready_q;

    uop_t    sel_uop;
    logic    iss_valid_q;
    uop_t    iss_uop_q;
    wb_bus_t self_bus;

    // ------------------------------------------------------------------
    // allocation and free count
    // ------------------------------------------------------------------

    assign disp_fire  = disp.valid && disp_ready_q;
    assign issue_fire = |grant;

    // lowest empty slot takes the dispatch
    always_comb begin
        logic found;
        found = 1'b0;
        alloc = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!entry_valid[i] && !found) begin
                found    = 1'b1;
                alloc[i] = disp_fire;
            end
        end
    end

    assign free_d = free_q - IQ_CNT_W'(disp_fire) + IQ_CNT_W'(issue_fire);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            free_q       <= IQ_CNT_W'(IQ_SIZE);
            disp_ready_q <= 1'b1;
        end else if (flush_i) begin
            free_q       <= IQ_CNT_W'(IQ_SIZE);
            disp_ready_q <= 1'b1;
        end else begin
            free_q       <= free_d;
            disp_ready_q <= (free_d >= IQ_CNT_W'(1));
        end
    end

    assign disp.ready = disp_ready_q;

    // ------------------------------------------------------------------
    // entries and oldest-ready pick
    // ------------------------------------------------------------------

    for (genvar i = 0; i < IQ_SIZE; i++) begin : gen_entry
        iq_entry u_entry (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .flush_i  (flush_i),
            .alloc_i  (alloc[i]),
            .uop_i    (disp.uop),
            .cdb_i    (cdb_i),
            .self_i   (self_bus),
            .issue_i  (grant[i]),
            .valid_o  (entry_valid[i]),
            .ready_o  (entry_ready[i]),
            .uop_o    (entry_uop[i])
        );
    end

    age_select u_age_select (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .flush_i   (flush_i),
        .valid_i   (entry_valid),
        .ready_i   (entry_ready),
        .alloc_i   (alloc),
        .advance_i (advance),
        .grant_o   (grant)
    );

    // grant is one-hot
    always_comb begin
        sel_uop = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (grant[i]) begin
                sel_uop = entry_uop[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // issue register and stall
    // ------------------------------------------------------------------

    // result slot free now or drained this cycle
    assign advance = !res_valid_o || res_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss_valid_q <= 1'b0;
        end else if (flush_i) begin
            iss_valid_q <= 1'b0;
        end else if (advance) begin
            iss_valid_q <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            iss_uop_q <= sel_uop;
        end
    end

    alu_exec u_alu_exec (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .load_i      (iss_valid_q && advance),
        .op_i        (iss_uop_q.op),
        .a_i         (iss_uop_q.src[0].val),
        .b_i         (iss_uop_q.src[1].val),
        .tag_i       (iss_uop_q.dst),
        .res_valid_o (res_valid_o),
        .res_tag_o   (res_tag_o),
        .res_data_o  (res_data_o),
        .hold_i      (!advance)
    );

    // result handshake doubles as local wakeup
    assign self_bus.valid = res_valid_o && res_ready_i;
    assign self_bus.tag   = res_tag_o;
    assign self_bus.data  = res_data_o;

endmodule

`default_nettype wire

//--- hw/alu_iq_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_iq_top
    import core_types_pkg::*;
    import iq_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n_i,
    input  wire             flush_i,

    input  logic            disp_valid_i,
    output logic            disp_ready_o,
    input  alu_op_e         disp_op_i,
    input  rob_tag_t        disp_dst_i,
    input  logic [1:0]      disp_src_rdy_i,
    input  rob_tag_t [1:0]  disp_src_tag_i,
    input  word_t [1:0]     disp_src_val_i,

    input  logic            cdb_valid_i,
    input  rob_tag_t        cdb_tag_i,
    input  word_t           cdb_data_i,

    input  logic            res_ready_i,
    output logic            res_valid_o,
    output rob_tag_t        res_tag_o,
    output word_t           res_data_o
);

    iq_dispatch_if u_disp_if ();

    uop_t    disp_uop;
    wb_bus_t cdb;

    // ------------------------------------------------------------------
    // pack dispatch ports, top acts as the sender side
    // ------------------------------------------------------------------

    always_comb begin
        disp_uop.op  = disp_op_i;
        disp_uop.dst = disp_dst_i;
        for (int s = 0; s < 2; s++) begin
            disp_uop.src[s].rdy = disp_src_rdy_i[s];
            disp_uop.src[s].tag = disp_src_tag_i[s];
            disp_uop.src[s].val = disp_src_val_i[s];
        end
    end

    assign u_disp_if.valid = disp_valid_i;
    assign u_disp_if.uop   = disp_uop;
    assign disp_ready_o    = u_disp_if.ready;

    assign cdb.valid = cdb_valid_i;
    assign cdb.tag   = cdb_tag_i;
    assign cdb.data  = cdb_data_i;

    alu_iq u_alu_iq (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .disp        (u_disp_if.receiver),
        .cdb_i       (cdb),
        .res_ready_i (res_ready_i),
        .res_valid_o (res_valid_o),
        .res_tag_o   (res_tag_o),
        .res_data_o  (res_data_o)
    );

endmodule

`default_nettype wire

//--- dv/alu_iq_sva.sv
`timescale 1ns/1ps
`default_nettype none

module alu_iq_sva
    import core_types_pkg::*;
    import iq_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  wire                 flush_i,
    input  logic [IQ_SIZE-1:0]  entry_valid_i,
    input  logic                disp_ready_i,
    input  logic                advance_i,
    input  logic                res_valid_i,
    input  logic                res_ready_i,
    input  rob_tag_t            res_tag_i,
    input  word_t               res_data_i
);

    // at most one entry leaves per cycle
    one_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        !flush_i |=> $onehot0($past(entry_valid_i) & ~entry_valid_i))
        else $error("more than one entry issued in a cycle");

    // free count has to agree with the occupied entries
    full_blocks_dispatch: assert property (@(posedge clk) disable iff (!arst_n_i)
        (&entry_valid_i) |-> !disp_ready_i)
        else $error("dispatch ready while every entry is occupied");

    // held result keeps tag and data until taken
    held_result_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid_i && !res_ready_i && !flush_i
        |=> res_valid_i && $stable(res_tag_i) && $stable(res_data_i))
        else $error("held result changed or vanished");

    stall_blocks_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        !advance_i && !flush_i |=> (($past(entry_valid_i) & ~entry_valid_i) == '0))
        else $error("entry issued while the pipe stalls");

endmodule

bind alu_iq alu_iq_sva u_alu_iq_sva (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .entry_valid_i (entry_valid),
    .disp_ready_i  (disp_ready_q),
    .advance_i     (advance),
    .res_valid_i   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_tag_i     (res_tag_o),
    .res_data_i    (res_data_o)
);

`default_nettype wire

//--- dv/alu_iq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_iq_tb
    import core_types_pkg::*;
    import iq_pkg::*;
();

    localparam int N_OPS    = 400;
    localparam int N_TAGS   = 1 << ROB_TAG_W;
    localparam int CLK_NS   = 100;
    localparam int TAG_FREE = 0;
    localparam int TAG_ALU  = 1;
    localparam int TAG_CDB  = 2;

    logic           clk;
    logic           arst_n_i;
    logic           flush_i;
    logic           disp_valid_i;
    logic           disp_ready_o;
    alu_op_e        disp_op_i;
    rob_tag_t       disp_dst_i;
    logic [1:0]     disp_src_rdy_i;
    rob_tag_t [1:0] disp_src_tag_i;
    word_t [1:0]    disp_src_val_i;
    logic           cdb_valid_i;
    rob_tag_t       cdb_tag_i;
    word_t          cdb_data_i;
    logic           res_ready_i;
    logic           res_valid_o;
    rob_tag_t       res_tag_o;
    word_t          res_data_o;

    // ------------------------------------------------------------------
    // model state with one slot per ROB tag
    // ------------------------------------------------------------------

    logic     alu_busy [N_TAGS];
    logic     cdb_pend [N_TAGS];
    word_t    cdb_val [N_TAGS];
    alu_op_e  m_op [N_TAGS];
    logic     m_rdy [N_TAGS][2];
    rob_tag_t m_tag [N_TAGS][2];
    word_t    m_val [N_TAGS][2];

    logic [31:0] seed;
    int          mismatches;
    int          other_errs;
    int          n_sent;
    int          n_results;
    int          n_inflight;
    int          cycle;
    int          flushes_done;
    logic        saw_full;

    alu_iq_top u_alu_iq_top (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .disp_valid_i   (disp_valid_i),
        .disp_ready_o   (disp_ready_o),
        .disp_op_i      (disp_op_i),
        .disp_dst_i     (disp_dst_i),
        .disp_src_rdy_i (disp_src_rdy_i),
        .disp_src_tag_i (disp_src_tag_i),
        .disp_src_val_i (disp_src_val_i),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .cdb_data_i     (cdb_data_i),
        .res_ready_i    (res_ready_i),
        .res_valid_o    (res_valid_o),
        .res_tag_o      (res_tag_o),
        .res_data_o     (res_data_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // low bits of the LCG are weak, take the middle ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:8]) % n;
    endfunction

    function automatic word_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic word_t expect_alu(input alu_op_e op, input word_t a, input word_t b);
        word_t r;
        int    sh;
        sh = int'(b & 32'h1f);
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a + ~b + 32'd1;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_SLL: r = a << sh;
            ALU_SRL: r = a >> sh;
            default: begin
                // when signs differ the negative one is smaller
                if (a[31] != b[31]) begin
                    r = {31'd0, a[31]};
                end else begin
                    r = {31'd0, (a < b)};
                end
            end
        endcase
        return r;
    endfunction

    // random tag in the given state or -1 when there is none
    function automatic int pick_tag(input int kind);
        int list[$];
        for (int t = 0; t < N_TAGS; t++) begin
            if ((kind == TAG_FREE && !alu_busy[t] && !cdb_pend[t]) ||
                (kind == TAG_ALU && alu_busy[t]) ||
                (kind == TAG_CDB && cdb_pend[t])) begin
                list.push_back(t);
            end
        end
        if (list.size() == 0) begin
            return -1;
        end
        return list[rand_below(list.size())];
    endfunction

    task automatic check_eq(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0d ns: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        other_errs++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic wake_model(input rob_tag_t tag, input word_t data);
        for (int t = 0; t < N_TAGS; t++) begin
            for (int s = 0; s < 2; s++) begin
                if (alu_busy[t] && !m_rdy[t][s] && (m_tag[t][s] == tag)) begin
                    m_rdy[t][s] = 1'b1;
                    m_val[t][s] = data;
                end
            end
        end
    endtask

    task automatic clear_model();
        for (int t = 0; t < N_TAGS; t++) begin
            alu_busy[t] = 1'b0;
            cdb_pend[t] = 1'b0;
        end
        n_inflight = 0;
    endtask

    // ------------------------------------------------------------------
    // check outputs, drive inputs and predict the next edge
    // ------------------------------------------------------------------

    task automatic run_cycle(input logic allow_disp);
        word_t exp_res;
        logic  fire_res;
        int    dst;
        int    mode;
        int    src;
        int    cdb_pick;

        exp_res = '0;
        if (res_valid_o) begin
            if (!alu_busy[res_tag_o]) begin
                report_error($sformatf("result for tag %0d which is not in flight", res_tag_o));
            end else if (!(m_rdy[res_tag_o][0] && m_rdy[res_tag_o][1])) begin
                report_error($sformatf("tag %0d issued before its sources were ready",
                                       res_tag_o));
            end else begin
                exp_res = expect_alu(m_op[res_tag_o], m_val[res_tag_o][0],
                                     m_val[res_tag_o][1]);
                check_eq(res_data_o, exp_res, $sformatf("data of tag %0d", res_tag_o));
            end
        end
        if (!disp_ready_o) begin
            saw_full = 1'b1;
            if (n_inflight < IQ_SIZE) begin
                report_error("dispatch refused while entries are free");
            end
        end

        // first quarter of every 64 cycles stalls the result port
        res_ready_i = (cycle % 64 >= 16) && (rand_below(4) != 0);
        fire_res    = res_valid_o && res_ready_i && alu_busy[res_tag_o];

        disp_valid_i = 1'b0;
        dst = pick_tag(TAG_FREE);
        if (allow_disp && disp_ready_o && (dst >= 0) && (rand_below(4) != 0)) begin
            alu_busy[dst] = 1'b1;
            m_op[dst]     = alu_op_e'(rand_below(8));
            for (int s = 0; s < 2; s++) begin
                mode = rand_below(8);
                src  = -1;
                if (mode == 4) begin
                    src = pick_tag(TAG_CDB);
                end else if (mode == 5) begin
                    // fresh tag the CDB delivers later
                    src = pick_tag(TAG_FREE);
                    if (src >= 0) begin
                        cdb_pend[src] = 1'b1;
                        cdb_val[src]  = rand_word();
                    end
                end else if (mode >= 6) begin
                    src = pick_tag(TAG_ALU);
                    if (src == dst) begin
                        src = -1;
                    end
                end
                m_rdy[dst][s] = (src < 0);
                m_tag[dst][s] = (src < 0) ? rob_tag_t'(rand_below(N_TAGS)) : rob_tag_t'(src);
                // waiting source carries junk
                m_val[dst][s] = rand_word();
                disp_src_rdy_i[s] = m_rdy[dst][s];
                disp_src_tag_i[s] = m_tag[dst][s];
                disp_src_val_i[s] = m_val[dst][s];
            end
            disp_valid_i = 1'b1;
            disp_op_i    = m_op[dst];
            disp_dst_i   = rob_tag_t'(dst);
            n_sent++;
            n_inflight++;
        end

        cdb_valid_i = 1'b0;
        cdb_pick    = pick_tag(TAG_CDB);
        if ((cdb_pick >= 0) && (rand_below(2) == 0)) begin
            cdb_valid_i = 1'b1;
            cdb_tag_i   = rob_tag_t'(cdb_pick);
            cdb_data_i  = cdb_val[cdb_pick];
        end

        // dispatch is recorded first so same-cycle wakeups reach it
        if (fire_res) begin
            wake_model(res_tag_o, exp_res);
            alu_busy[res_tag_o] = 1'b0;
            n_inflight--;
            n_results++;
        end
        if (cdb_valid_i) begin
            wake_model(cdb_tag_i, cdb_data_i);
            cdb_pend[cdb_tag_i] = 1'b0;
        end
        cycle++;
    endtask

    task automatic do_flush();
        flush_i      = 1'b1;
        disp_valid_i = 1'b0;
        cdb_valid_i  = 1'b0;
        res_ready_i  = 1'b0;
        @(negedge clk);
        flush_i = 1'b0;
        clear_model();
        if (!disp_ready_o) begin
            report_error("dispatch not ready in the cycle after flush");
        end
        if (res_valid_o) begin
            report_error("result still valid after flush");
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        seed           = 32'h1ed9;
        mismatches     = 0;
        other_errs     = 0;
        n_sent         = 0;
        n_results      = 0;
        cycle          = 0;
        flushes_done   = 0;
        saw_full       = 1'b0;
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        disp_valid_i   = 1'b0;
        disp_op_i      = ALU_ADD;
        disp_dst_i     = '0;
        disp_src_rdy_i = '0;
        disp_src_tag_i = '0;
        disp_src_val_i = '0;
        cdb_valid_i    = 1'b0;
        cdb_tag_i      = '0;
        cdb_data_i     = '0;
        res_ready_i    = 1'b0;
        clear_model();

        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        if (!disp_ready_o) begin
            report_error("dispatch not ready after reset");
        end

        while ((n_sent < N_OPS) || (n_inflight > 0)) begin
            @(negedge clk);
            // flush only with a full queue so ready has to come back
            if ((flushes_done < 2) && (n_sent >= (flushes_done + 1) * N_OPS / 3) &&
                !disp_ready_o) begin
                do_flush();
                flushes_done++;
            end else begin
                run_cycle(n_sent < N_OPS);
            end
        end

        // nothing may come out once the queue has drained
        disp_valid_i = 1'b0;
        cdb_valid_i  = 1'b0;
        res_ready_i  = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (res_valid_o) begin
                report_error("result appeared after all micro-ops completed");
            end
        end
        if (!saw_full) begin
            report_error("dispatch ready never fell, queue was never full");
        end
        if (flushes_done < 2) begin
            report_error("flush was not applied twice to a full queue");
        end

        $display("results %0d, mismatches %0d, other errors %0d",
                 n_results, mismatches, other_errs);
        if ((mismatches == 0) && (other_errs == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog allows 40 cycles per operation
    initial begin
        #(N_OPS * 40 * CLK_NS);
        $display("timeout: run did not finish within %0d cycles", N_OPS * 40);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/core_types_pkg.sv
hw/iq_pkg.sv
hw/iq_dispatch_if.sv
hw/iq_entry.sv
hw/age_select.sv
hw/alu_exec.sv
hw/alu_iq.sv
hw/alu_iq_top.sv
dv/alu_iq_sva.sv
dv/alu_iq_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the ALU issue queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module alu_iq_tb -f flist.f -o alu_iq_sim

./obj_dir/alu_iq_sim | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
